// ==== common/ic_pkg.sv ====
`default_nettype none

package ic_pkg;

  // stream widths
  localparam int DATA_BITS  = 16;
  localparam int ADDR_BITS  = 2;
  localparam int MSG_BITS   = ADDR_BITS + DATA_BITS;
  localparam int REPLY_BITS = DATA_BITS + 1;

  // spi framing
  localparam int FRAME_BITS = 20;
  localparam int CNT_BITS   = $clog2(FRAME_BITS + 1);

  // flag positions, shared by both directions of a frame
  // host side: host-valid and host-ready, minion side: reply-valid and space
  localparam int FLAG_VAL = FRAME_BITS - 1;
  localparam int FLAG_RDY = FRAME_BITS - 2;

  localparam int N_ROUTES = 4;

  typedef logic [DATA_BITS-1:0]  data_t;
  typedef logic [ADDR_BITS-1:0]  addr_t;
  // address on top, then data
  typedef logic [MSG_BITS-1:0]   msg_t;
  // source index on top, then data
  typedef logic [REPLY_BITS-1:0] reply_t;
  typedef logic [FRAME_BITS-1:0] frame_t;
  typedef logic [CNT_BITS-1:0]   bit_cnt_t;

  // router address map
  localparam addr_t ADDR_IN_XBAR  = 2'd0;
  localparam addr_t ADDR_OUT_XBAR = 2'd1;
  localparam addr_t ADDR_IN_CTRL  = 2'd2;
  localparam addr_t ADDR_OUT_CTRL = 2'd3;

endpackage

`default_nettype wire

// ==== spi/spi_minion.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_minion (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           cs,
  input  logic           sclk,
  input  logic           mosi,
  output logic           miso,
  output ic_pkg::msg_t   req_msg,
  output logic           req_val,
  input  logic           req_rdy,
  input  ic_pkg::reply_t rsp_msg,
  input  logic           rsp_val,
  output logic           rsp_rdy,
  output logic           minion_parity,
  output logic           adapter_parity
);
  import ic_pkg::*;

  // two flops to synchronize, the third only for edge detection
  logic [2:0] sclk_sync;
  logic [2:0] cs_sync;
  logic [1:0] mosi_sync;

  logic sclk_rise;
  logic sclk_fall;
  logic cs_fall;
  logic selected;

  frame_t   rx_shift;
  frame_t   rx_next;
  frame_t   tx_shift;
  frame_t   tx_frame;
  bit_cnt_t bit_cnt;
  logic     frame_done;
  logic     reply_sent;

  logic   req_load;
  reply_t rsp_slot;
  logic   rsp_slot_val;
  logic   rsp_load;
  logic   rsp_pop;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sclk_sync <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end else begin
      sclk_sync <= {sclk_sync[1:0], sclk};
      cs_sync   <= {cs_sync[1:0], cs};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sclk_rise = sclk_sync[1] && !sclk_sync[2];
  assign sclk_fall = !sclk_sync[1] && sclk_sync[2];
  assign cs_fall   = !cs_sync[1] && cs_sync[2];
  assign selected  = !cs_sync[1];

  // msb first, so the host-valid flag ends up in the top bit
  assign rx_next    = {rx_shift[FRAME_BITS-2:0], mosi_sync[1]};
  assign frame_done = selected && sclk_rise && (bit_cnt == bit_cnt_t'(FRAME_BITS - 1));

  always_ff @(posedge clk) begin
    if (selected && sclk_rise) begin
      rx_shift <= rx_next;
    end
  end

  // stops at FRAME_BITS so extra sclk edges cannot end a second frame
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
    end else if (cs_fall) begin
      bit_cnt <= '0;
    end else if (selected && sclk_rise && (bit_cnt < FRAME_BITS)) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // reply frame as seen at the start of the transfer
  always_comb begin
    tx_frame           = '0;
    tx_frame[FLAG_VAL] = rsp_slot_val;
    tx_frame[FLAG_RDY] = !req_val;
    if (rsp_slot_val) begin
      tx_frame[REPLY_BITS-1:0] = rsp_slot;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_shift   <= '0;
      reply_sent <= 1'b0;
    end else if (cs_fall) begin
      tx_shift   <= tx_frame;
      reply_sent <= rsp_slot_val;
    end else if (selected && sclk_fall) begin
      tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
    end
  end

  assign miso = tx_shift[FRAME_BITS-1];

  // request slot, a full slot drops the incoming message
  assign req_load = frame_done && rx_next[FLAG_VAL] && !req_val;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_val       <= 1'b0;
      minion_parity <= 1'b0;
    end else if (req_load) begin
      req_val       <= 1'b1;
      minion_parity <= ^rx_next[MSG_BITS-1:0];
    end else if (req_rdy) begin
      req_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_load) begin
      req_msg <= rx_next[MSG_BITS-1:0];
    end
  end

  // reply slot, popped only once the host has seen it and said it is ready
  assign rsp_rdy  = !rsp_slot_val;
  assign rsp_load = rsp_val && rsp_rdy;
  assign rsp_pop  = frame_done && reply_sent && rx_next[FLAG_RDY];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_slot_val   <= 1'b0;
      adapter_parity <= 1'b0;
    end else if (rsp_load) begin
      rsp_slot_val   <= 1'b1;
      adapter_parity <= ^rsp_msg;
    end else if (rsp_pop) begin
      rsp_slot_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_load) begin
      rsp_slot <= rsp_msg;
    end
  end

endmodule

`default_nettype wire

// ==== arbiter_router/stream_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_router (
  input  logic                        clk,
  input  logic                        arst_n,
  input  ic_pkg::msg_t                in_msg,
  input  logic                        in_val,
  output logic                        in_rdy,
  output ic_pkg::data_t               out_msg,
  output logic [ic_pkg::N_ROUTES-1:0] out_val,
  input  logic [ic_pkg::N_ROUTES-1:0] out_rdy
);
  import ic_pkg::*;

  addr_t buf_addr;
  data_t buf_data;
  logic  buf_val;
  logic  accept;
  logic  drain;

  // only the addressed output can empty the buffer
  assign drain  = buf_val && out_rdy[buf_addr];
  assign in_rdy = !buf_val || drain;
  assign accept = in_val && in_rdy;

  // data is shared by all outputs, val picks the one that takes it
  assign out_msg = buf_data;

  always_comb begin
    for (int i = 0; i < N_ROUTES; i++) begin
      out_val[i] = buf_val && (buf_addr == addr_t'(i));
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      buf_val <= 1'b0;
    end else if (accept) begin
      buf_val <= 1'b1;
    end else if (drain) begin
      buf_val <= 1'b0;
    end
  end

  // address comes off the top of the message
  always_ff @(posedge clk) begin
    if (accept) begin
      buf_addr <= in_msg[MSG_BITS-1 -: ADDR_BITS];
      buf_data <= in_msg[DATA_BITS-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== arbiter_router/stream_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_arbiter (
  input  logic           clk,
  input  logic           arst_n,
  input  ic_pkg::data_t  in_msg [2],
  input  logic [1:0]     in_val,
  output logic [1:0]     in_rdy,
  output ic_pkg::reply_t out_msg,
  output logic           out_val,
  input  logic           out_rdy
);
  import ic_pkg::*;

  // input that wins a tie
  logic prio;
  logic grant_idx;
  logic grant;
  logic space;

  // buffer is free when empty or emptying this cycle
  assign space = !out_val || out_rdy;

  always_comb begin
    grant_idx = prio;
    if (!in_val[prio]) begin
      grant_idx = !prio;
    end
  end

  assign grant = space && in_val[grant_idx];

  // the loser always sees rdy low
  always_comb begin
    in_rdy            = '0;
    in_rdy[grant_idx] = grant;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_val <= 1'b0;
      prio    <= 1'b0;
    end else if (grant) begin
      out_val <= 1'b1;
      prio    <= !grant_idx;
    end else if (out_rdy) begin
      out_val <= 1'b0;
    end
  end

  // tag each stored message with where it came from
  always_ff @(posedge clk) begin
    if (grant) begin
      out_msg <= {grant_idx, in_msg[grant_idx]};
    end
  end

endmodule

`default_nettype wire

// ==== src/blocking_crossbar.sv ====
`timescale 1ns/1ns
`default_nettype none

module blocking_crossbar #(
  parameter int N_INPUTS  = 2,
  parameter int N_OUTPUTS = 2
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  ic_pkg::data_t        in_msg [N_INPUTS],
  input  logic [N_INPUTS-1:0]  in_val,
  output logic [N_INPUTS-1:0]  in_rdy,
  output ic_pkg::data_t        out_msg [N_OUTPUTS],
  output logic [N_OUTPUTS-1:0] out_val,
  input  logic [N_OUTPUTS-1:0] out_rdy,
  input  ic_pkg::data_t        ctrl_msg,
  input  logic                 ctrl_val,
  output logic                 ctrl_rdy
);
  import ic_pkg::*;

  // whole control word is kept, the path indices are folded out of it
  data_t sel;
  int    path_in;
  int    path_out;
  logic  path_stalled;

  // low digit picks the input, the next one picks the output
  // so a single input leaves the low bit to the output and vice versa
  always_comb begin
    path_in  = int'(sel) % N_INPUTS;
    path_out = (int'(sel) / N_INPUTS) % N_OUTPUTS;
  end

  always_comb begin
    in_rdy  = '0;
    out_val = '0;
    for (int o = 0; o < N_OUTPUTS; o++) begin
      out_msg[o] = in_msg[path_in];
    end
    out_val[path_out] = in_val[path_in];
    in_rdy[path_in]   = out_rdy[path_out];
  end

  // a message waiting on the open path must not be rerouted mid-stall
  assign path_stalled = in_val[path_in] && !out_rdy[path_out];
  assign ctrl_rdy     = !path_stalled;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sel <= '0;
    end else if (ctrl_val && ctrl_rdy) begin
      sel <= ctrl_msg;
    end
  end

endmodule

`default_nettype wire

// ==== src/interconnect_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module interconnect_top (
  input  logic clk,
  input  logic arst_n,
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  output logic minion_parity,
  output logic adapter_parity
);
  import ic_pkg::*;

  // minion to router and arbiter to minion
  msg_t   req_msg;
  logic   req_val;
  logic   req_rdy;
  reply_t rsp_msg;
  logic   rsp_val;
  logic   rsp_rdy;

  data_t               route_msg;
  logic [N_ROUTES-1:0] route_val;
  logic [N_ROUTES-1:0] route_rdy;

  data_t      in_xbar_in_msg [1];
  data_t      in_xbar_out_msg [2];
  logic [1:0] in_xbar_out_val;
  logic [1:0] in_xbar_out_rdy;

  data_t      out_xbar_in_msg [2];
  logic [1:0] out_xbar_in_val;
  logic [1:0] out_xbar_in_rdy;
  data_t      out_xbar_out_msg [1];
  logic       out_xbar_out_val;
  logic       out_xbar_out_rdy;

  data_t      arb_in_msg [2];
  logic [1:0] arb_in_val;
  logic [1:0] arb_in_rdy;

  spi_minion minion (
    .clk           (clk),
    .arst_n        (arst_n),
    .cs            (cs),
    .sclk          (sclk),
    .mosi          (mosi),
    .miso          (miso),
    .req_msg       (req_msg),
    .req_val       (req_val),
    .req_rdy       (req_rdy),
    .rsp_msg       (rsp_msg),
    .rsp_val       (rsp_val),
    .rsp_rdy       (rsp_rdy),
    .minion_parity (minion_parity),
    .adapter_parity(adapter_parity)
  );

  stream_router router (
    .clk    (clk),
    .arst_n (arst_n),
    .in_msg (req_msg),
    .in_val (req_val),
    .in_rdy (req_rdy),
    .out_msg(route_msg),
    .out_val(route_val),
    .out_rdy(route_rdy)
  );

  assign in_xbar_in_msg[0] = route_msg;

  // output 0 goes to the arbiter, output 1 is the accelerator slot
  blocking_crossbar #(
    .N_INPUTS (1),
    .N_OUTPUTS(2)
  ) input_xbar (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_msg  (in_xbar_in_msg),
    .in_val  (route_val[ADDR_IN_XBAR]),
    .in_rdy  (route_rdy[ADDR_IN_XBAR]),
    .out_msg (in_xbar_out_msg),
    .out_val (in_xbar_out_val),
    .out_rdy (in_xbar_out_rdy),
    .ctrl_msg(route_msg),
    .ctrl_val(route_val[ADDR_IN_CTRL]),
    .ctrl_rdy(route_rdy[ADDR_IN_CTRL])
  );

  // accelerator slot is a plain loopback into output_xbar input 1
  assign out_xbar_in_msg[0]        = route_msg;
  assign out_xbar_in_msg[1]        = in_xbar_out_msg[1];
  assign out_xbar_in_val           = {in_xbar_out_val[1], route_val[ADDR_OUT_XBAR]};
  assign route_rdy[ADDR_OUT_XBAR]  = out_xbar_in_rdy[0];
  assign in_xbar_out_rdy[1]        = out_xbar_in_rdy[1];

  blocking_crossbar #(
    .N_INPUTS (2),
    .N_OUTPUTS(1)
  ) output_xbar (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_msg  (out_xbar_in_msg),
    .in_val  (out_xbar_in_val),
    .in_rdy  (out_xbar_in_rdy),
    .out_msg (out_xbar_out_msg),
    .out_val (out_xbar_out_val),
    .out_rdy (out_xbar_out_rdy),
    .ctrl_msg(route_msg),
    .ctrl_val(route_val[ADDR_OUT_CTRL]),
    .ctrl_rdy(route_rdy[ADDR_OUT_CTRL])
  );

  // arbiter input index becomes the source tag of the reply
  assign arb_in_msg[0]      = in_xbar_out_msg[0];
  assign arb_in_msg[1]      = out_xbar_out_msg[0];
  assign arb_in_val         = {out_xbar_out_val, in_xbar_out_val[0]};
  assign in_xbar_out_rdy[0] = arb_in_rdy[0];
  assign out_xbar_out_rdy   = arb_in_rdy[1];

  stream_arbiter arbiter (
    .clk    (clk),
    .arst_n (arst_n),
    .in_msg (arb_in_msg),
    .in_val (arb_in_val),
    .in_rdy (arb_in_rdy),
    .out_msg(rsp_msg),
    .out_val(rsp_val),
    .out_rdy(rsp_rdy)
  );

endmodule

`default_nettype wire

// ==== tests/interconnect_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module interconnect_tb;
  import ic_pkg::*;

  localparam int MAX_FRAMES     = 400;
  // a frame with its gap takes 177 cycles
  localparam int FRAME_CYCLES   = 200;
  localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_CYCLES;
  localparam int REPLY_POLLS    = 4;
  localparam int unsigned SEED  = 32'h9ebc_7312;

  logic clk;
  logic arst_n;
  logic cs;
  logic sclk;
  logic mosi;
  logic miso;
  logic minion_parity;
  logic adapter_parity;

  // reference model state
  data_t  in_sel;
  data_t  out_sel;
  reply_t exp_q[$];
  logic   exp_minion;
  logic   exp_adapter;

  string test_name;
  int    frame_cnt;
  int    cycle_cnt;

  interconnect_top uut (
    .clk           (clk),
    .arst_n        (arst_n),
    .cs            (cs),
    .sclk          (sclk),
    .mosi          (mosi),
    .miso          (miso),
    .minion_parity (minion_parity),
    .adapter_parity(adapter_parity)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("** FAIL **");
        $fatal(1, "simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
      end
    end
  end

  task automatic abort_run(input string reason);
    $display("** FAIL **");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error %s: %s expected %h actual %h", test_name, what, expected, actual);
      abort_run($sformatf("%s mismatch in %s", what, test_name));
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // addr 0 leaves input_xbar on output 0 for an even select, else it loops back
  function automatic reply_t route_reply(input addr_t a, input data_t d);
    if (a == ADDR_IN_XBAR && !in_sel[0]) begin
      return reply_t'({1'b0, d});
    end
    return reply_t'({1'b1, d});
  endfunction

  // a data path is open when every crossbar on it points the right way
  function automatic bit path_open(input addr_t a);
    if (a == ADDR_IN_XBAR) begin
      return !in_sel[0] || out_sel[0];
    end
    if (a == ADDR_OUT_XBAR) begin
      return !out_sel[0];
    end
    return 1'b1;
  endfunction

  // msb first, mosi set while sclk is low, miso taken just before the rising edge
  task automatic transfer_frame(input frame_t tx, output frame_t rx);
    rx = '0;
    @(negedge clk);
    cs = 1'b0;
    wait_cycles(4);
    for (int i = FRAME_BITS - 1; i >= 0; i--) begin
      mosi = tx[i];
      wait_cycles(4);
      rx[i] = miso;
      sclk = 1'b1;
      wait_cycles(4);
      sclk = 1'b0;
    end
    wait_cycles(4);
    cs   = 1'b1;
    mosi = 1'b0;
    wait_cycles(8);
    frame_cnt++;
    check_value("minion parity", exp_minion, minion_parity);
  endtask

  task automatic poll_minion(input logic host_rdy, output frame_t rx);
    transfer_frame({1'b0, host_rdy, 18'b0}, rx);
  endtask

  task automatic send_msg(input addr_t a, input data_t d);
    frame_t rx;
    msg_t   msg;
    reply_t exp_r;
    msg   = {a, d};
    exp_r = route_reply(a, d);
    exp_minion = ^msg;
    transfer_frame({1'b1, 1'b0, msg}, rx);
    // both slots are empty whenever a request goes out
    check_value("request frame flags", {2'b01, 18'b0}, rx);
    case (a)
      ADDR_IN_CTRL:  in_sel = d;
      ADDR_OUT_CTRL: out_sel = d;
      default:       exp_q.push_back(exp_r);
    endcase
  endtask

  // optionally holds the first reply once with host-ready low
  task automatic collect_replies(input bit hold_first);
    frame_t rx;
    int     tries;
    bit     held;
    bit     hold;
    tries = 0;
    held  = 1'b0;
    while (exp_q.size() > 0) begin
      if (tries >= REPLY_POLLS) begin
        abort_run($sformatf("no reply reached the host after %0d polls in %s",
                            REPLY_POLLS, test_name));
      end
      hold = hold_first && !held;
      poll_minion(!hold, rx);
      tries++;
      if (rx[FLAG_VAL]) begin
        check_value("reply frame", {2'b11, 1'b0, exp_q[0]}, rx);
        exp_adapter = ^exp_q[0];
        if (hold) begin
          held = 1'b1;
        end else begin
          void'(exp_q.pop_front());
          tries = 0;
        end
      end else begin
        check_value("idle frame", {2'b01, 18'b0}, rx);
      end
      check_value("adapter parity", exp_adapter, adapter_parity);
    end
  endtask

  initial begin
    int unsigned seed_val;
    addr_t       a;
    data_t       d;
    int          op;
    frame_t      rx;

    seed_val    = $urandom(SEED);
    arst_n      = 1'b0;
    cs          = 1'b1;
    sclk        = 1'b0;
    mosi        = 1'b0;
    in_sel      = '0;
    out_sel     = '0;
    exp_minion  = 1'b0;
    exp_adapter = 1'b0;
    frame_cnt   = 0;
    test_name   = "reset";

    wait_cycles(4);
    arst_n = 1'b1;
    wait_cycles(2);

    poll_minion(1'b1, rx);
    check_value("first poll", {2'b01, 18'b0}, rx);
    check_value("adapter parity", 1'b0, adapter_parity);

    test_name = "default_path";
    send_msg(ADDR_IN_XBAR, data_t'($urandom));
    collect_replies(1'b0);

    // both selects odd, so address 0 goes through the accelerator loopback
    test_name = "loopback_path";
    send_msg(ADDR_IN_CTRL, 16'd1);
    send_msg(ADDR_OUT_CTRL, 16'd1);
    send_msg(ADDR_IN_XBAR, data_t'($urandom));
    collect_replies(1'b1);

    test_name = "output_xbar_path";
    send_msg(ADDR_OUT_CTRL, 16'd0);
    send_msg(ADDR_OUT_XBAR, data_t'($urandom));
    collect_replies(1'b0);

    test_name = "random_mix";
    while (frame_cnt < MAX_FRAMES - 4) begin
      op = $urandom_range(3, 0);
      d  = data_t'($urandom);
      if (op == 0) begin
        a = ($urandom_range(1, 0) == 0) ? ADDR_IN_CTRL : ADDR_OUT_CTRL;
        send_msg(a, d);
      end else begin
        if (path_open(ADDR_IN_XBAR) && path_open(ADDR_OUT_XBAR)) begin
          a = ($urandom_range(1, 0) == 0) ? ADDR_IN_XBAR : ADDR_OUT_XBAR;
        end else if (path_open(ADDR_IN_XBAR)) begin
          a = ADDR_IN_XBAR;
        end else begin
          a = ADDR_OUT_XBAR;
        end
        send_msg(a, d);
        collect_replies($urandom_range(3, 0) == 0);
      end
    end

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
common/ic_pkg.sv
spi/spi_minion.sv
arbiter_router/stream_router.sv
arbiter_router/stream_arbiter.sv
src/blocking_crossbar.sv
src/interconnect_top.sv
tests/interconnect_tb.sv
